//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= wb_core_tb
RTL_TOP   ?= wb_core
BUILD_DIR ?= obj_dir
SIM       ?= sim
VFLAGS    ?= --binary -j 0 --timescale 1ns/100ps -Wno-fatal
PASS_TEXT ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(SIM)

run: build
	@out="$$(./$(BUILD_DIR)/$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(filter src/%,$(shell cat $(FILELIST)))

clean:
	rm -rf $(BUILD_DIR)

//--- src/exec_unit.sv
// Pipelined execution unit with parameterized latency
// Result leaves the last stage tagged with its instruction ID

module exec_unit #(
    parameter int LATENCY = 1,
    parameter int OP      = wb_pkg::UNIT_ALU
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  wb_pkg::id_t             id,
    input  logic [wb_pkg::XLEN-1:0] a,
    input  logic [wb_pkg::XLEN-1:0] b,
    output wb_pkg::unit_wb_t        wb
);
    import wb_pkg::*;

    // Pipeline stages, index 0 is filled from the inputs
    logic            valid_q  [LATENCY];
    id_t             id_q     [LATENCY];
    logic [XLEN-1:0] result_q [LATENCY];

    logic [XLEN-1:0] op_result;

    // Operation, multiply keeps the low XLEN bits
    assign op_result = (OP == UNIT_MUL) ? (a * b) : (a + b);

    // Valid chain
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < LATENCY; s++)
                valid_q[s] <= 1'b0;
        end else begin
            valid_q[0] <= start;
            for (int s = 1; s < LATENCY; s++)
                valid_q[s] <= valid_q[s-1];
        end
    end

    // ID and result shift along with valid
    always_ff @(posedge clk) begin
        id_q[0]     <= id;
        result_q[0] <= op_result;
        for (int s = 1; s < LATENCY; s++) begin
            id_q[s]     <= id_q[s-1];
            result_q[s] <= result_q[s-1];
        end
    end

    // Final stage report
    assign wb.done = valid_q[LATENCY-1];
    assign wb.id   = id_q[LATENCY-1];
    assign wb.rd   = result_q[LATENCY-1];

endmodule

//--- src/id_tracking.sv
// ID pool: next ID to issue, oldest unretired ID and occupancy count

module id_tracking (
    input  logic        clk,
    input  logic        rst,
    input  logic        issued,
    input  logic        retired,
    tracking_if.ids     ti,
    output wb_pkg::id_t oldest_id,
    output logic        empty
);
    import wb_pkg::*;

    // IDs are handed out and freed in the same repeating order,
    // so two wrapping pointers act as a queue of IDs
    id_t next_id;
    id_t oldest_ptr;

    // Number of IDs in use, 0 to MAX_INFLIGHT
    logic [$clog2(MAX_INFLIGHT+1)-1:0] inflight_count;

    //////////////////////////////////////////////////////////////
    // Pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id    <= '0;
            oldest_ptr <= '0;
        end else begin
            if (issued)
                next_id <= next_id + 1'b1;
            if (retired)
                oldest_ptr <= oldest_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////
    // Occupancy
    // Issue and retire in one cycle leave the count unchanged
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else if (issued && !retired) begin
            inflight_count <= inflight_count + 1'b1;
        end else if (!issued && retired) begin
            inflight_count <= inflight_count - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////
    // Outputs
    assign ti.issue_id     = next_id;
    assign ti.id_available = (inflight_count < MAX_INFLIGHT);
    assign oldest_id       = oldest_ptr;
    assign empty           = (inflight_count == 0);

endmodule

//--- src/register_file.sv
// Register file written at retirement, one combinational read port

module register_file (
    input  logic                    clk,
    input  logic                    rst,
    rf_wb_if.rf                     rf_wb,
    input  wb_pkg::reg_addr_t       raddr,
    output logic [wb_pkg::XLEN-1:0] rdata
);
    import wb_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    // Register 0 is never written, rd_nzero masks it
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < REG_COUNT; r++)
                regs[r] <= '0;
        end else if (rf_wb.retired && rf_wb.rd_nzero) begin
            regs[rf_wb.rd_addr] <= rf_wb.rd_data;
        end
    end

    assign rdata = regs[raddr];

endmodule

//--- src/wb_core.sv
// Top level: ID pool, adder and multiplier, writeback control and register file

module wb_core (
    input  logic                    clk,
    input  logic                    rst,
    // Issue
    input  logic                    issue_valid,
    input  wb_pkg::unit_sel_t       issue_unit,
    input  wb_pkg::reg_addr_t       issue_rd,
    input  logic [wb_pkg::XLEN-1:0] issue_a,
    input  logic [wb_pkg::XLEN-1:0] issue_b,
    output logic                    issue_ready,
    // Retirement
    output logic                    retired,
    output wb_pkg::id_t             retired_id,
    output wb_pkg::reg_addr_t       retired_rd,
    output logic [wb_pkg::XLEN-1:0] retired_data,
    // Register read
    input  wb_pkg::reg_addr_t       rf_raddr,
    output logic [wb_pkg::XLEN-1:0] rf_rdata
);
    import wb_pkg::*;

    tracking_if ti ();
    rf_wb_if    rf_wb ();

    unit_wb_t unit_wb [NUM_WB_UNITS];
    id_t      oldest_id;
    logic     queue_empty;
    logic     retired_or_next;

    //////////////////////////////////////////////////////////////
    // Issue handshake
    assign issue_ready        = ti.id_available;
    assign ti.issued          = issue_valid & ti.id_available;
    assign ti.issue_unit      = issue_unit;
    assign ti.inflight_packet = '{rd_addr: issue_rd};

    id_tracking id_fifos (
        .clk, .rst, .issued(ti.issued), .retired(retired_or_next),
        .ti, .oldest_id, .empty(queue_empty)
    );

    //////////////////////////////////////////////////////////////
    // Execution units
    exec_unit #(.LATENCY(ALU_LATENCY), .OP(UNIT_ALU)) alu_i (
        .clk, .rst, .start(ti.issued && (issue_unit == UNIT_ALU)),
        .id(ti.issue_id), .a(issue_a), .b(issue_b), .wb(unit_wb[UNIT_ALU])
    );

    exec_unit #(.LATENCY(MUL_LATENCY), .OP(UNIT_MUL)) mul_i (
        .clk, .rst, .start(ti.issued && (issue_unit == UNIT_MUL)),
        .id(ti.issue_id), .a(issue_a), .b(issue_b), .wb(unit_wb[UNIT_MUL])
    );

    //////////////////////////////////////////////////////////////
    // Writeback and register file
    write_back wb_i (
        .clk, .rst, .unit_wb, .ti, .rf_wb, .retired_or_next,
        .instruction_queue_empty(queue_empty), .oldest_id
    );

    register_file rf_i (.clk, .rst, .rf_wb, .raddr(rf_raddr), .rdata(rf_rdata));

    assign retired      = rf_wb.retired;
    assign retired_id   = rf_wb.id;
    assign retired_rd   = rf_wb.rd_addr;
    assign retired_data = rf_wb.rd_data;

endmodule

//--- src/wb_ifaces.sv
// Issue tracking interface and register file writeback interface

interface tracking_if;
    import wb_pkg::*;

    // Issue handshake towards the ID pool
    logic             issued;
    logic             id_available;
    id_t              issue_id;
    unit_sel_t        issue_unit;
    inflight_packet_t inflight_packet;

    // Issue side of the top level
    modport issue (
        output issued, issue_unit, inflight_packet,
        input  id_available, issue_id
    );

    // ID pool
    modport ids (
        output id_available, issue_id
    );

    // Writeback control only watches
    modport wb (
        input issued, id_available, issue_id, issue_unit, inflight_packet
    );
endinterface

interface rf_wb_if;
    import wb_pkg::*;

    logic            retired;
    id_t             id;
    reg_addr_t       rd_addr;
    logic            rd_nzero;
    logic [XLEN-1:0] rd_data;

    modport writeback (output retired, id, rd_addr, rd_nzero, rd_data);
    modport rf (input retired, id, rd_addr, rd_nzero, rd_data);
endinterface

//--- src/wb_pkg.sv
// Shared widths, counts and types for the writeback and retirement stage
// Unit indices, ID and per-unit result packet

package wb_pkg;

    //////////////////////////////////////////////////////////////
    // Sizes
    localparam int XLEN         = 32;
    localparam int MAX_INFLIGHT = 4;
    localparam int NUM_WB_UNITS = 2;
    localparam int REG_COUNT    = 32;

    // Execution latencies in cycles
    localparam int ALU_LATENCY = 1;
    localparam int MUL_LATENCY = 3;

    // Unit indices, also used as the operation select of exec_unit
    localparam int UNIT_ALU = 0;
    localparam int UNIT_MUL = 1;

    //////////////////////////////////////////////////////////////
    // Types
    typedef logic [$clog2(MAX_INFLIGHT)-1:0] id_t;
    typedef logic [$clog2(NUM_WB_UNITS)-1:0] unit_sel_t;
    typedef logic [$clog2(REG_COUNT)-1:0]    reg_addr_t;

    // Result report from one unit, valid when done is set
    typedef struct packed {
        logic            done;
        id_t             id;
        logic [XLEN-1:0] rd;
    } unit_wb_t;

    // Per-ID metadata kept while the instruction is in flight
    typedef struct packed {
        reg_addr_t rd_addr;
    } inflight_packet_t;

endpackage

//--- src/write_back.sv
// Writeback control: per-ID result buffer, pending tracking and in-order retirement

module write_back (
    input  logic             clk,
    input  logic             rst,
    input  wb_pkg::unit_wb_t unit_wb [wb_pkg::NUM_WB_UNITS],
    tracking_if.wb           ti,
    rf_wb_if.writeback       rf_wb,
    output logic             retired_or_next,
    input  logic             instruction_queue_empty,
    input  wb_pkg::id_t      oldest_id
);
    import wb_pkg::*;

    // Result buffer and destination table, both indexed by ID
    logic [XLEN-1:0]  results_by_id [MAX_INFLIGHT];
    inflight_packet_t packet_table  [MAX_INFLIGHT];

    unit_sel_t id_unit_select   [MAX_INFLIGHT];
    unit_sel_t id_unit_select_r [MAX_INFLIGHT];

    logic [MAX_INFLIGHT-1:0] id_done_new;
    logic [MAX_INFLIGHT-1:0] id_issued_one_hot;
    logic [MAX_INFLIGHT-1:0] id_retiring_one_hot;
    logic [MAX_INFLIGHT-1:0] id_inuse;
    logic [MAX_INFLIGHT-1:0] id_pending;
    logic [MAX_INFLIGHT-1:0] id_pending_r;

    logic             retiring;
    id_t              id_retiring;
    inflight_packet_t retiring_packet;

    //////////////////////////////////////////////////////////////
    // Done and issue decode
    always_comb begin
        id_done_new = '0;
        for (int u = 0; u < NUM_WB_UNITS; u++) begin
            if (unit_wb[u].done)
                id_done_new[unit_wb[u].id] = 1'b1;
        end
    end

    always_comb begin
        id_issued_one_hot = '0;
        id_issued_one_hot[ti.issue_id] = ti.issued;
    end

    //////////////////////////////////////////////////////////////
    // Unit select and result buffer
    // Free IDs take issue_unit directly for single-cycle units
    for (genvar i = 0; i < MAX_INFLIGHT; i++) begin : g_buffer
        always_ff @(posedge clk) begin
            if (id_issued_one_hot[i])
                id_unit_select_r[i] <= ti.issue_unit;
            if (id_done_new[i])
                results_by_id[i] <= unit_wb[id_unit_select[i]].rd;
        end
        assign id_unit_select[i] = id_inuse[i] ? id_unit_select_r[i] : ti.issue_unit;
    end

    // In use from issue until the unit reports done
    always_ff @(posedge clk) begin
        if (rst)
            id_inuse <= '0;
        else
            id_inuse <= id_issued_one_hot | (id_inuse & ~id_done_new);
    end

    // Destination register per ID
    always_ff @(posedge clk) begin
        if (ti.issued)
            packet_table[ti.issue_id] <= ti.inflight_packet;
    end

    //////////////////////////////////////////////////////////////
    // Retirement
    // Pending from done until the ID retires
    assign id_pending = id_done_new | (id_pending_r & ~id_retiring_one_hot);

    always_ff @(posedge clk) begin
        if (rst)
            id_pending_r <= '0;
        else
            id_pending_r <= id_pending;
    end

    // Oldest ID retires next cycle once its result is in
    assign retired_or_next = id_pending[oldest_id] & ~instruction_queue_empty;

    always_ff @(posedge clk) begin
        if (rst)
            retiring <= 1'b0;
        else
            retiring <= retired_or_next;
    end

    always_ff @(posedge clk) begin
        id_retiring <= oldest_id;
    end

    always_comb begin
        id_retiring_one_hot = '0;
        id_retiring_one_hot[id_retiring] = retiring;
    end

    assign retiring_packet = packet_table[id_retiring];

    // Register file write
    assign rf_wb.retired  = retiring;
    assign rf_wb.id       = id_retiring;
    assign rf_wb.rd_addr  = retiring_packet.rd_addr;
    assign rf_wb.rd_nzero = |retiring_packet.rd_addr;
    assign rf_wb.rd_data  = results_by_id[id_retiring];

endmodule

//--- test/wb_core_tb.sv
// Testbench for wb_core: issue stimulus, reference queue of expected retirements
// Retirement, latency, ready and register file checks, watchdog and report

module wb_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import wb_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int RANDOM_OPS  = 40;
    // Upper bound on operations issued over all tests
    localparam int TOTAL_OPS   = 60;
    localparam int WATCHDOG_NS = (TOTAL_OPS * 20 + 100) * CLK_PERIOD;

    // Timing check applied to an expected retirement
    localparam logic [1:0] MODE_ANY   = 2'd0;
    localparam logic [1:0] MODE_EXACT = 2'd1;
    localparam logic [1:0] MODE_NEXT  = 2'd2;

    typedef struct packed {
        int              issue_cycle;
        logic [1:0]      mode;
        unit_sel_t       unit;
        id_t             id;
        reg_addr_t       rd;
        logic [XLEN-1:0] data;
    } exp_t;

    logic            clk;
    logic            rst;
    logic            issue_valid;
    unit_sel_t       issue_unit;
    reg_addr_t       issue_rd;
    logic [XLEN-1:0] issue_a;
    logic [XLEN-1:0] issue_b;
    logic            issue_ready;
    logic            retired;
    id_t             retired_id;
    reg_addr_t       retired_rd;
    logic [XLEN-1:0] retired_data;
    reg_addr_t       rf_raddr;
    logic [XLEN-1:0] rf_rdata;

    exp_t            exp_q[$];
    logic [XLEN-1:0] reg_model [REG_COUNT];
    id_t             next_id = '0;
    int              cycle = 0;
    int              last_retire = 0;
    int              errors = 0;
    int              start_errors = 0;
    int              tests_passed = 0;
    int              tests_failed = 0;
    int              issues = 0;
    string           test_name = "none";

    wb_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Cycle count, read only on falling edges
    always @(posedge clk) cycle++;

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////////////////
    // Helpers
    task automatic compare_field(input string field, input logic [XLEN-1:0] expected,
                                 input logic [XLEN-1:0] actual);
        assert (actual == expected)
        else begin
            $display("Fail %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    // Hold the operation until an edge with ready high, then record what must retire
    task automatic issue_op(input unit_sel_t unit, input reg_addr_t rd,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input logic [1:0] mode);
        exp_t e;
        issue_valid = 1'b1;
        issue_unit  = unit;
        issue_rd    = rd;
        issue_a     = a;
        issue_b     = b;
        do @(negedge clk); while (!issue_ready);
        #1;
        e.issue_cycle = cycle + 1;
        e.mode        = mode;
        e.unit        = unit;
        e.id          = next_id;
        e.rd          = rd;
        // Multiply keeps the low XLEN bits
        e.data        = (unit == UNIT_MUL) ? a * b : a + b;
        exp_q.push_back(e);
        next_id++;
        issues++;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    // Wait until every issued operation has retired and reached the register file
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        @(posedge clk);
        #1;
        test_name    = name;
        start_errors = errors;
    endtask

    task automatic finish_test();
        if (errors == start_errors) begin
            $display("Test %s passed", test_name);
            tests_passed++;
        end else begin
            $display("Test %s failed", test_name);
            tests_failed++;
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Retirement checker, outputs are stable on the falling edge
    always @(negedge clk) begin : retire_check
        exp_t e;
        int   lat;
        if (!rst) begin
            if (retired) begin
                assert (exp_q.size() != 0)
                else begin
                    $display("%s: retirement with no operation outstanding", test_name);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    e   = exp_q.pop_front();
                    lat = (e.unit == UNIT_MUL) ? MUL_LATENCY : ALU_LATENCY;
                    compare_field("retired_id", e.id, retired_id);
                    compare_field("retired_rd", e.rd, retired_rd);
                    compare_field("retired_data", e.data, retired_data);
                    if (e.mode == MODE_EXACT)
                        compare_field("retire cycle", e.issue_cycle + lat, cycle);
                    if (e.mode == MODE_NEXT)
                        compare_field("retire cycle", last_retire + 1, cycle);
                    // Register 0 is never written
                    if (e.rd != 0)
                        reg_model[e.rd] = e.data;
                    last_retire = cycle;
                end
            end
            // An ID is free again from the edge that starts its retired cycle
            // Ready is high exactly while fewer than MAX_INFLIGHT are outstanding
            compare_field("issue_ready", (exp_q.size() < MAX_INFLIGHT), issue_ready);
        end
    end

    //////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        void'($urandom(63));
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_unit  = '0;
        issue_rd    = '0;
        issue_a     = '0;
        issue_b     = '0;
        rf_raddr    = '0;
        for (int r = 0; r < REG_COUNT; r++)
            reg_model[r] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle after reset
        start_test("reset");
        repeat (3) begin
            @(negedge clk);
            compare_field("issue_ready", 1, issue_ready);
            compare_field("retired", 0, retired);
        end
        finish_test();

        start_test("random_results");
        for (int i = 0; i < RANDOM_OPS; i++)
            issue_op(unit_sel_t'($urandom_range(1)), reg_addr_t'($urandom_range(31)),
                     $urandom, $urandom, MODE_ANY);
        drain();
        finish_test();

        // Lone ops retire at their latency, a younger ADD waits behind a MUL
        start_test("in_order");
        issue_op(UNIT_ALU, 5'd1, 32'h0000_1234, 32'h0000_4321, MODE_EXACT);
        drain();
        issue_op(UNIT_MUL, 5'd2, 32'h0001_0003, 32'h0000_0007, MODE_EXACT);
        drain();
        issue_op(UNIT_MUL, 5'd3, 32'hffff_fff1, 32'h0000_0011, MODE_EXACT);
        issue_op(UNIT_ALU, 5'd4, 32'h8000_0000, 32'h8000_0001, MODE_NEXT);
        drain();
        finish_test();

        start_test("back_pressure");
        for (int i = 0; i < 4; i++)
            issue_op(UNIT_MUL, reg_addr_t'(8 + i), $urandom, $urandom, MODE_ANY);
        drain();
        finish_test();

        // Writes to register 0 are dropped
        start_test("register_file");
        issue_op(UNIT_ALU, 5'd0, 32'd5, 32'd7, MODE_ANY);
        issue_op(UNIT_MUL, 5'd20, 32'd1000, 32'd3000, MODE_ANY);
        issue_op(UNIT_ALU, 5'd31, 32'hdead_0000, 32'h0000_beef, MODE_ANY);
        issue_op(UNIT_MUL, 5'd0, 32'd9, 32'd9, MODE_ANY);
        drain();
        for (int r = 0; r < REG_COUNT; r++) begin
            rf_raddr = reg_addr_t'(r);
            @(negedge clk);
            compare_field($sformatf("rf[%0d]", r), reg_model[r], rf_rdata);
            @(posedge clk);
            #1;
        end
        finish_test();

        $display("Tests passed %0d, tests failed %0d, failed checks %0d, operations issued %0d",
                 tests_passed, tests_failed, errors, issues);
        if (errors == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/wb_pkg.sv
src/wb_ifaces.sv
src/id_tracking.sv
src/exec_unit.sv
src/write_back.sv
src/register_file.sv
src/wb_core.sv
test/wb_core_tb.sv
